//--- include/video_defs.svh
`ifndef VIDEO_DEFS_SVH
`define VIDEO_DEFS_SVH

//----------------------------------------------------------------------------
// Clocking

`define CLK_MHZ        50
`define PIXEL_MHZ      25

// System clocks per pixel
`define PIXEL_DIV      (`CLK_MHZ / `PIXEL_MHZ)

//----------------------------------------------------------------------------
// 640x480 at 60 Hz timing, 800 pixels per line and 525 lines per frame

`define SCREEN_WIDTH   640
`define SCREEN_HEIGHT  480

`define H_FRONT        16
`define H_SYNC         96
`define H_BACK         48

`define V_FRONT        10
`define V_SYNC         2
`define V_BACK         33

//----------------------------------------------------------------------------
// Channel and coordinate widths, channels at least 4 bits

`define W_RED          4
`define W_GREEN        4
`define W_BLUE         4

`define W_X            10
`define W_Y            10

`endif

//--- source/video_pkg.sv
`default_nettype none

`include "video_defs.svh"

package video_pkg;

    // Where a scan axis is within its line or frame
    typedef enum logic [1:0]
    {
        ACTIVE      = 2'd0,
        FRONT_PORCH = 2'd1,
        SYNC        = 2'd2,
        BACK_PORCH  = 2'd3
    }
    sync_phase_t;

    // Screen coordinates
    typedef logic [`W_X - 1:0] x_t;
    typedef logic [`W_Y - 1:0] y_t;

endpackage

`default_nettype wire

//--- source/sync_axis.sv
`timescale 1ns/1ps
`default_nettype none

`include "video_defs.svh"

module sync_axis
    import video_pkg::*;
# (
    parameter int active_len = `SCREEN_WIDTH,
    parameter int front_len  = `H_FRONT,
    parameter int sync_len   = `H_SYNC,
    parameter int back_len   = `H_BACK
)
(
    input  wire                clk,
    input  wire                rst_n,
    input  wire                step,

    output logic [`W_X - 1:0]  count,
    output sync_phase_t        phase,
    output logic               wrap
);

    localparam int w_cnt = `W_X;
    localparam int total = active_len + front_len + sync_len + back_len;

    // Last count of each interval
    localparam logic [w_cnt - 1:0] active_last = w_cnt'(active_len - 1);
    localparam logic [w_cnt - 1:0] front_last  = w_cnt'(active_len + front_len - 1);
    localparam logic [w_cnt - 1:0] sync_last   =
        w_cnt'(active_len + front_len + sync_len - 1);
    localparam logic [w_cnt - 1:0] total_last  = w_cnt'(total - 1);

    logic [w_cnt - 1:0] count_next;
    sync_phase_t        phase_next;

    //------------------------------------------------------------------------

    assign wrap = step && (count == total_last);

    always_comb
    begin
        count_next = wrap ? '0 : count + 1'b1;
    end

    // Phase moves on when the count leaves the last position of an interval
    always_comb
    begin
        phase_next = phase;

        case (phase)
            ACTIVE:      if (count == active_last) phase_next = FRONT_PORCH;
            FRONT_PORCH: if (count == front_last)  phase_next = SYNC;
            SYNC:        if (count == sync_last)   phase_next = BACK_PORCH;
            BACK_PORCH:  if (count == total_last)  phase_next = ACTIVE;
            default:     phase_next = ACTIVE;
        endcase
    end

    //------------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            count <= '0;
            phase <= ACTIVE;
        end
        else if (step)
        begin
            count <= count_next;
            phase <= phase_next;
        end
    end

endmodule

`default_nettype wire

//--- source/vga_timing.sv
`timescale 1ns/1ps
`default_nettype none

`include "video_defs.svh"

module vga_timing
    import video_pkg::*;
(
    input  wire   clk,
    input  wire   rst_n,

    output logic  pixel_en,
    output x_t    x,
    output y_t    y,
    output logic  hsync,
    output logic  vsync
);

    localparam int w_div = $clog2(`PIXEL_DIV + 1);

    localparam logic [w_div - 1:0] div_last = w_div'(`PIXEL_DIV - 1);

    logic [w_div - 1:0] div_cnt;

    logic [`W_X - 1:0]  h_count;
    logic [`W_X - 1:0]  v_count;
    sync_phase_t        h_phase;
    sync_phase_t        v_phase;
    logic               h_wrap;

    //------------------------------------------------------------------------
    // Pixel strobe, one clock in every PIXEL_DIV

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            div_cnt  <= '0;
            pixel_en <= 1'b0;
        end
        else
        begin
            pixel_en <= (div_cnt == div_last);
            div_cnt  <= (div_cnt == div_last) ? '0 : div_cnt + 1'b1;
        end
    end

    //------------------------------------------------------------------------
    // Scan axes, the vertical one steps at the end of each line

    sync_axis
    # (
        .active_len ( `SCREEN_WIDTH  ),
        .front_len  ( `H_FRONT       ),
        .sync_len   ( `H_SYNC        ),
        .back_len   ( `H_BACK        )
    )
    h_axis_i
    (
        .clk   ( clk      ),
        .rst_n ( rst_n    ),
        .step  ( pixel_en ),
        .count ( h_count  ),
        .phase ( h_phase  ),
        .wrap  ( h_wrap   )
    );

    sync_axis
    # (
        .active_len ( `SCREEN_HEIGHT ),
        .front_len  ( `V_FRONT       ),
        .sync_len   ( `V_SYNC        ),
        .back_len   ( `V_BACK        )
    )
    v_axis_i
    (
        .clk   ( clk      ),
        .rst_n ( rst_n    ),
        .step  ( h_wrap   ),
        .count ( v_count  ),
        .phase ( v_phase  ),
        .wrap  (          )
    );

    assign x = h_count;
    assign y = v_count;

    // Active-low syncs, loaded with the same pixel as the color
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            hsync <= 1'b1;
            vsync <= 1'b1;
        end
        else if (pixel_en)
        begin
            hsync <= (h_phase != SYNC);
            vsync <= (v_phase != SYNC);
        end
    end

endmodule

`default_nettype wire

//--- source/color_bar_pattern.sv
`timescale 1ns/1ps
`default_nettype none

`include "video_defs.svh"

module color_bar_pattern
    import video_pkg::*;
(
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    pixel_en,
    input  wire x_t                x,
    input  wire y_t                y,

    output logic [`W_RED   - 1:0]  red,
    output logic [`W_GREEN - 1:0]  green,
    output logic [`W_BLUE  - 1:0]  blue
);

    // Bars are 128 pixels wide, so the bar number is x above bit 6
    logic [`W_X - 8:0]       bar;
    logic [3:0]              level;

    logic [3:0]              red_4;
    logic [3:0]              green_4;
    logic [3:0]              blue_4;

    logic [`W_RED   - 1:0]   red_next;
    logic [`W_GREEN - 1:0]   green_next;
    logic [`W_BLUE  - 1:0]   blue_next;

    assign bar   = x[`W_X - 1:7];
    assign level = x[6:3];

    //------------------------------------------------------------------------

    always_comb
    begin
        red_4   = '0;
        green_4 = '0;
        blue_4  = '0;

        // Blanking area stays black
        if (x < `SCREEN_WIDTH && y < `SCREEN_HEIGHT)
        begin
            case (bar)
                0: red_4 = level;
                1: green_4 = level;
                2: blue_4 = level;
                3:
                begin
                    red_4   = level;
                    green_4 = level;
                end
                4:
                begin
                    green_4 = level;
                    blue_4  = level;
                end
                default: ;
            endcase
        end
    end

    // Intensity in the top four bits of each channel
    always_comb
    begin
        red_next   = '0;
        green_next = '0;
        blue_next  = '0;

        red_next   [`W_RED   - 1 -: 4] = red_4;
        green_next [`W_GREEN - 1 -: 4] = green_4;
        blue_next  [`W_BLUE  - 1 -: 4] = blue_4;
    end

    //------------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            red   <= '0;
            green <= '0;
            blue  <= '0;
        end
        else if (pixel_en)
        begin
            red   <= red_next;
            green <= green_next;
            blue  <= blue_next;
        end
    end

endmodule

`default_nettype wire

//--- source/video_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "video_defs.svh"

module video_top
    import video_pkg::*;
(
    input  wire                    clk,
    input  wire                    rst_n,

    // Pixel clock strobe for the video DAC
    output logic                   pixel_en,

    output logic                   hsync,
    output logic                   vsync,

    output logic [`W_RED   - 1:0]  red,
    output logic [`W_GREEN - 1:0]  green,
    output logic [`W_BLUE  - 1:0]  blue
);

    // Scan position from timing to pattern
    x_t x;
    y_t y;

    //------------------------------------------------------------------------

    vga_timing vga_timing_i
    (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .pixel_en ( pixel_en ),
        .x        ( x        ),
        .y        ( y        ),
        .hsync    ( hsync    ),
        .vsync    ( vsync    )
    );

    color_bar_pattern color_bar_pattern_i
    (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .pixel_en ( pixel_en ),
        .x        ( x        ),
        .y        ( y        ),
        .red      ( red      ),
        .green    ( green    ),
        .blue     ( blue     )
    );

endmodule

`default_nettype wire

//--- tests/video_top_sva.sv
`timescale 1ns/1ps
`default_nettype none

`include "video_defs.svh"

module video_top_checks
(
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    pixel_en,
    input  wire                    hsync,
    input  wire                    vsync,
    input  wire [`W_RED   - 1:0]   red,
    input  wire [`W_GREEN - 1:0]   green,
    input  wire [`W_BLUE  - 1:0]   blue
);

    // Strobe is a single clock wide
    pixel_en_single: assert property (@(posedge clk) disable iff (!rst_n)
        pixel_en |=> !pixel_en)
        else $error("pixel_en was high on two consecutive clocks");

    // Outputs only move on the edge that takes a pixel
    outputs_on_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        !$past(pixel_en) |-> $stable({hsync, vsync, red, green, blue}))
        else $error("Video outputs changed without a pixel strobe");

    // Vertical sync lines lie in the blanking area
    black_in_vsync: assert property (@(posedge clk) disable iff (!rst_n)
        !vsync |-> (red == '0 && green == '0 && blue == '0))
        else $error("Color was not black during vertical sync");

    // Reset values hold one clock after reset is seen low
    reset_values: assert property (@(posedge clk)
        !rst_n |=> (hsync && vsync && !pixel_en &&
                    red == '0 && green == '0 && blue == '0))
        else $error("Outputs left their reset values while in reset");

endmodule

`default_nettype wire

//--- tests/tb_video_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "video_defs.svh"

module tb_video_top;

    localparam int h_total        = `SCREEN_WIDTH + `H_FRONT + `H_SYNC + `H_BACK;
    localparam int v_total        = `SCREEN_HEIGHT + `V_FRONT + `V_SYNC + `V_BACK;
    localparam int frame_pixels   = h_total * v_total;
    localparam int max_extra      = 1000;
    localparam int timeout_cycles = 850000 + 2 * 2000;

    localparam int w_red   = `W_RED;
    localparam int w_green = `W_GREEN;
    localparam int w_blue  = `W_BLUE;

    // Starts low without an edge at time zero
    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  pixel_en;
    logic                  hsync;
    logic                  vsync;
    logic [w_red   - 1:0]  red;
    logic [w_green - 1:0]  green;
    logic [w_blue  - 1:0]  blue;

    int                    pixels_to_check;
    int                    pulse_count;
    int                    clocks_since_pulse;
    int                    cycle_count;
    logic                  scan_done;

    //------------------------------------------------------------------------

    video_top video_top_i
    (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .pixel_en ( pixel_en ),
        .hsync    ( hsync    ),
        .vsync    ( vsync    ),
        .red      ( red      ),
        .green    ( green    ),
        .blue     ( blue     )
    );

    bind video_top video_top_checks video_top_checks_i
    (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .pixel_en ( pixel_en ),
        .hsync    ( hsync    ),
        .vsync    ( vsync    ),
        .red      ( red      ),
        .green    ( green    ),
        .blue     ( blue     )
    );

    always #10 clk = ~clk;

    //------------------------------------------------------------------------
    // Expected outputs for pixel n in scan order

    function automatic void reference_pixel
    (
        input  int                   n,
        output logic                 exp_hs,
        output logic                 exp_vs,
        output logic [w_red   - 1:0] exp_r,
        output logic [w_green - 1:0] exp_g,
        output logic [w_blue  - 1:0] exp_b
    );
        int         px;
        int         py;
        int         level;
        logic [3:0] r4;
        logic [3:0] g4;
        logic [3:0] b4;

        px = n % h_total;
        py = (n / h_total) % v_total;

        exp_hs = !(px >= `SCREEN_WIDTH + `H_FRONT &&
                   px <  `SCREEN_WIDTH + `H_FRONT + `H_SYNC);
        exp_vs = !(py >= `SCREEN_HEIGHT + `V_FRONT &&
                   py <  `SCREEN_HEIGHT + `V_FRONT + `V_SYNC);

        r4 = 4'd0;
        g4 = 4'd0;
        b4 = 4'd0;
        if (px < `SCREEN_WIDTH && py < `SCREEN_HEIGHT)
        begin
            // Ramp of 16 steps, 8 pixels each, inside a 128 pixel bar
            level = (px / 8) % 16;
            case (px / 128)
                0: r4 = level[3:0];
                1: g4 = level[3:0];
                2: b4 = level[3:0];
                3:
                begin
                    r4 = level[3:0];
                    g4 = level[3:0];
                end
                default:
                begin
                    g4 = level[3:0];
                    b4 = level[3:0];
                end
            endcase
        end

        exp_r = w_red'(r4)   << (w_red   - 4);
        exp_g = w_green'(g4) << (w_green - 4);
        exp_b = w_blue'(b4)  << (w_blue  - 4);
    endfunction

    task automatic check_value
    (
        input string       test_name,
        input int          index,
        input logic [31:0] expected,
        input logic [31:0] actual
    );
        if (actual !== expected)
        begin
            $display("** Error %s at pixel %0d: expected %0h, actual %0h",
                     test_name, index, expected, actual);
            $display("*** FAILED ***");
            $fatal(1, "Mismatch in %s", test_name);
        end
    endtask

    task automatic verify_idle_outputs(input string test_name);
        check_value({test_name, " hsync"}, 0, 32'(1'b1), 32'(hsync));
        check_value({test_name, " vsync"}, 0, 32'(1'b1), 32'(vsync));
        check_value({test_name, " red"}, 0, 32'(0), 32'(red));
        check_value({test_name, " green"}, 0, 32'(0), 32'(green));
        check_value({test_name, " blue"}, 0, 32'(0), 32'(blue));
    endtask

    task automatic compare_pixel(input int index);
        logic                 exp_hs;
        logic                 exp_vs;
        logic [w_red   - 1:0] exp_r;
        logic [w_green - 1:0] exp_g;
        logic [w_blue  - 1:0] exp_b;

        reference_pixel(index, exp_hs, exp_vs, exp_r, exp_g, exp_b);
        check_value("hsync", index, 32'(exp_hs), 32'(hsync));
        check_value("vsync", index, 32'(exp_vs), 32'(vsync));
        check_value("red", index, 32'(exp_r), 32'(red));
        check_value("green", index, 32'(exp_g), 32'(green));
        check_value("blue", index, 32'(exp_b), 32'(blue));
    endtask

    //------------------------------------------------------------------------
    // Comparison, sampled on the falling edge between DUT updates

    always @(negedge clk)
    begin
        if (!rst_n)
        begin
            check_value("pixel_en in reset", 0, 32'(1'b0), 32'(pixel_en));
            verify_idle_outputs("reset");
            clocks_since_pulse = 0;
        end
        else
        begin
            clocks_since_pulse = clocks_since_pulse + 1;
            if (pixel_en)
            begin
                check_value("pixel_en interval", pulse_count,
                            32'(`PIXEL_DIV), 32'(clocks_since_pulse));
                clocks_since_pulse = 0;

                // Pulse n shows the pixel loaded by pulse n - 1
                if (pulse_count == 0)
                    verify_idle_outputs("before first pixel");
                else
                    compare_pixel(pulse_count - 1);

                pulse_count = pulse_count + 1;
                if (pulse_count == pixels_to_check + 1)
                    scan_done = 1'b1;
            end
            else if (pulse_count == 0)
            begin
                verify_idle_outputs("before first pixel");
            end
        end
    end

    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= timeout_cycles)
        begin
            $display("Timeout: the scan did not finish within %0d clock cycles",
                     timeout_cycles);
            $display("*** FAILED ***");
            $fatal(1, "Run stopped by timeout");
        end
    end

    //------------------------------------------------------------------------

    initial
    begin
        rst_n              = 1'b0;
        pulse_count        = 0;
        clocks_since_pulse = 0;
        cycle_count        = 0;
        scan_done          = 1'b0;

        void'($urandom(17270));
        // One full frame, then a random stretch into the next one
        pixels_to_check = frame_pixels + int'($urandom % (max_extra + 1));
        $display("Checking %0d pixels", pixels_to_check);

        repeat (3) @(negedge clk);
        rst_n <= 1'b1;

        wait (scan_done);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+include
source/video_pkg.sv
source/sync_axis.sv
source/vga_timing.sv
source/color_bar_pattern.sv
source/video_top.sv
tests/video_top_sva.sv
tests/tb_video_top.sv

//--- Makefile
# Verilator flow for the VGA color bar generator

TB_TOP  = tb_video_top
OBJ_DIR = obj_dir
LOG     = sim.log

.PHONY: all lint sim clean

all: sim

# Lint the RTL top level
lint:
	verilator --lint-only -Wall --timing -f verilog.f --top-module video_top

# Build and run the testbench, pass only if the log holds the pass message
sim:
	rm -f $(LOG)
	verilator --binary --timing --assert -f verilog.f \
		--top-module $(TB_TOP) -Mdir $(OBJ_DIR) -o V$(TB_TOP)
	./$(OBJ_DIR)/V$(TB_TOP) | tee $(LOG)
	@if grep -q '^\*\*\* PASSED \*\*\*$$' $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation did not pass"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
